//--- accessEngine.sv
/*
 * stage 2: serves controller register accesses internally and runs
 * a wishbone classic master toward chip RAM for chip accesses
 */
`timescale 1ns/1ns
`default_nettype none
`include "cpuBus_consts.svh"

module accessEngine (
    input  wire                 CLK80,
    input  wire                 RESETn,
    input  wire                 reqValid,
    input  wire cpuBusPkg::busReq req,
    input  wire                 rspReady,
    input  wire [31:0]          wbDatR,
    input  wire                 wbAck,
    output logic                reqReady,
    output logic                rspValid,
    output cpuBusPkg::busRsp    rsp,
    output logic                wbCyc,
    output logic                wbStb,
    output logic                wbWe,
    output logic [18:0]         wbAdr,
    output logic [3:0]          wbSel,
    output logic [31:0]         wbDatW
);

    typedef enum logic [1:0] {
        engIdle,
        engWb,
        engRsp
    } engState;

    engState     state;
    logic [31:0] regFile [`REG_COUNT];
    logic [2:0]  regIdx;
    logic [31:0] mergeWord;

    // only take a request with nothing in flight
    assign reqReady = (state == engIdle);
    assign regIdx   = req.addr.regView.regIdx;

    // write data merged into the old register per lane
    always_comb begin
        mergeWord = regFile[regIdx];
        for (int i = 0; i < 4; i++) begin
            if (req.lanes[i]) begin
                mergeWord[8*i +: 8] = req.wdata[8*i +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // control and register file
    //////////////////////////////////////////////////
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state    <= engIdle;
            rspValid <= 1'b0;
            wbCyc    <= 1'b0;
            wbStb    <= 1'b0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= 32'd0;
            end
        end else begin
            case (state)
                engIdle: begin
                    if (reqValid) begin
                        if (req.region == cpuBusPkg::regionReg) begin
                            // register hit answers next cycle
                            if (req.write) begin
                                regFile[regIdx] <= mergeWord;
                            end
                            rspValid <= 1'b1;
                            state    <= engRsp;
                        end else begin
                            // cyc and stb rise together
                            wbCyc <= 1'b1;
                            wbStb <= 1'b1;
                            state <= engWb;
                        end
                    end
                end
                engWb: begin
                    // drop the bus right after ack
                    if (wbAck) begin
                        wbCyc    <= 1'b0;
                        wbStb    <= 1'b0;
                        rspValid <= 1'b1;
                        state    <= engRsp;
                    end
                end
                engRsp: begin
                    if (rspReady) begin
                        rspValid <= 1'b0;
                        state    <= engIdle;
                    end
                end
                default: begin
                    state <= engIdle;
                end
            endcase
        end
    end

    // response and wishbone payload
    always_ff @(posedge CLK80) begin
        if (reqValid && reqReady) begin
            rsp.write <= req.write;
            rsp.rdata <= regFile[regIdx];
            wbWe      <= req.write;
            wbAdr     <= req.addr.chipView.longAddr;
            wbSel     <= req.lanes;
            wbDatW    <= req.wdata;
        end
        // chip read data arrives with ack
        if ((state == engWb) && wbAck) begin
            rsp.rdata <= wbDatR;
        end
    end

    wbStbInCycle: assert property (@(posedge CLK80) disable iff (!RESETn)
        wbStb |-> wbCyc)
        else $error("wishbone stb without cyc");

    // slave may only answer a strobe this master is waiting on
    wbAckInStrobe: assert property (@(posedge CLK80) disable iff (!RESETn)
        wbAck |-> (wbStb && (state == engWb)))
        else $error("wishbone ack outside an active strobe");

endmodule

`default_nettype wire

//--- chipRamSlave.sv
/*
 * wishbone classic chip RAM slave with byte selects
 * acks a fixed number of wait cycles after the strobe appears
 */
`timescale 1ns/1ns
`default_nettype none
`include "cpuBus_consts.svh"

module chipRamSlave (
    input  wire         CLK80,
    input  wire         RESETn,
    input  wire         wbCyc,
    input  wire         wbStb,
    input  wire         wbWe,
    input  wire [18:0]  wbAdr,
    input  wire [3:0]   wbSel,
    input  wire [31:0]  wbDatW,
    output logic [31:0] wbDatR,
    output logic        wbAck
);

    localparam int depthBits = $clog2(`CHIP_DEPTH);
    localparam int waitBits  = $clog2(`CHIP_WAIT + 2);

    logic [31:0]          mem [`CHIP_DEPTH];
    logic [waitBits-1:0]  waitCnt;
    logic [depthBits-1:0] memIdx;
    logic                 ackNow;

    // long address wraps at the implemented depth
    assign memIdx = wbAdr[depthBits-1:0];
    // wait count reached, access happens on this edge
    assign ackNow = wbCyc && wbStb && !wbAck && (waitCnt == waitBits'(`CHIP_WAIT));

    //////////////////////////////////////////////////
    // wait counter and ack
    //////////////////////////////////////////////////
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            waitCnt <= '0;
            wbAck   <= 1'b0;
        end else if (wbAck) begin
            // single cycle ack
            wbAck   <= 1'b0;
            waitCnt <= '0;
        end else if (wbCyc && wbStb) begin
            if (ackNow) begin
                wbAck   <= 1'b1;
                waitCnt <= '0;
            end else begin
                waitCnt <= waitCnt + 1'b1;
            end
        end else begin
            waitCnt <= '0;
        end
    end

    // array access, selected bytes only on writes
    always_ff @(posedge CLK80) begin
        if (ackNow) begin
            if (wbWe) begin
                for (int i = 0; i < 4; i++) begin
                    if (wbSel[i]) begin
                        mem[memIdx][8*i +: 8] <= wbDatW[8*i +: 8];
                    end
                end
            end else begin
                wbDatR <= mem[memIdx];
            end
        end
    end

endmodule

`default_nettype wire

//--- cpuBusPkg.sv
/*
 * shared bus types for the 68040 slave controller
 * referenced by scoped name from every stage and the top level
 */
`default_nettype none

package cpuBusPkg;

    // 68040 SIZ encoding
    typedef enum logic [1:0] {
        sizeLong = 2'b00,
        sizeByte = 2'b01,
        sizeWord = 2'b10,
        sizeLine = 2'b11
    } xferSize;

    // which internal target serves the cycle
    typedef enum logic {
        regionReg  = 1'b0,
        regionChip = 1'b1
    } busRegion;

    //////////////////////////////////////////////////
    // one address word, two decodes
    //////////////////////////////////////////////////
    typedef union packed {
        // register page view
        struct packed {
            logic [19:0] page;
            logic [6:0]  spare;
            logic [2:0]  regIdx;
            logic [1:0]  byteOff;
        } regView;
        // chip RAM view, long word address
        struct packed {
            logic [10:0] top;
            logic [18:0] longAddr;
            logic [1:0]  byteOff;
        } chipView;
    } cpuAddr;

    // decoded request, stage 1 to stage 2
    typedef struct packed {
        busRegion    region;
        logic        write;
        cpuAddr      addr;
        logic [3:0]  lanes;
        logic [31:0] wdata;
    } busReq;

    // completed access, stage 2 to stage 3
    typedef struct packed {
        logic        write;
        logic [31:0] rdata;
    } busRsp;

endpackage

`default_nettype wire

//--- cpuBusTop.f
+incdir+.
cpuBusPkg.sv
cycleDecode.sv
accessEngine.sv
chipRamSlave.sv
cycleTerm.sv
cpuBusTop.sv
tbCpuBus.sv

//--- cpuBusTop.sv
/*
 * 68040 slave bus controller top level
 * decode, access and termination stages plus the chip RAM slave
 */
`timescale 1ns/1ns
`default_nettype none

module cpuBusTop (
    input  wire                 CLK80,
    input  wire                 RESETn,
    input  wire                 tsN,
    input  wire [31:0]          addr,
    input  wire                 rw,
    input  wire cpuBusPkg::xferSize siz,
    input  wire [31:0]          dataIn,
    output logic                tackN,
    output logic                tbiN,
    output logic                tciN,
    output logic                busDrive,
    output logic [31:0]         dataOut,
    output logic                dataDrive
);

    // stage 1 to 2
    cpuBusPkg::busReq req;
    logic             reqValid;
    logic             reqReady;

    // stage 2 to 3
    cpuBusPkg::busRsp rsp;
    logic             rspValid;
    logic             rspReady;

    // wishbone to chip RAM
    logic             wbCyc;
    logic             wbStb;
    logic             wbWe;
    logic [18:0]      wbAdr;
    logic [3:0]       wbSel;
    logic [31:0]      wbDatW;
    logic [31:0]      wbDatR;
    logic             wbAck;

    cycleDecode decode (
        .CLK80    (CLK80),
        .RESETn   (RESETn),
        .tsN      (tsN),
        .addr     (addr),
        .rw       (rw),
        .siz      (siz),
        .dataIn   (dataIn),
        .reqReady (reqReady),
        .reqValid (reqValid),
        .req      (req)
    );

    accessEngine engine (
        .CLK80    (CLK80),
        .RESETn   (RESETn),
        .reqValid (reqValid),
        .req      (req),
        .rspReady (rspReady),
        .wbDatR   (wbDatR),
        .wbAck    (wbAck),
        .reqReady (reqReady),
        .rspValid (rspValid),
        .rsp      (rsp),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbSel    (wbSel),
        .wbDatW   (wbDatW)
    );

    chipRamSlave chipRam (
        .CLK80  (CLK80),
        .RESETn (RESETn),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbSel  (wbSel),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck)
    );

    cycleTerm term (
        .CLK80     (CLK80),
        .RESETn    (RESETn),
        .rspValid  (rspValid),
        .rsp       (rsp),
        .rspReady  (rspReady),
        .tackN     (tackN),
        .tbiN      (tbiN),
        .tciN      (tciN),
        .busDrive  (busDrive),
        .dataOut   (dataOut),
        .dataDrive (dataDrive)
    );

endmodule

`default_nettype wire

//--- cpuBus_consts.svh
/*
 * address map and sizing constants for the 68040 slave bus controller
 * include in any module that decodes regions or sizes the chip RAM
 */
`ifndef CPUBUS_CONSTS_SVH
`define CPUBUS_CONSTS_SVH

//////////////////////////////////////////////////
// register page
//////////////////////////////////////////////////

// upper 20 address bits of the controller register page
`define REG_PAGE 20'hDFF00
// 32-bit controller registers, matches the 3-bit index
`define REG_COUNT 8

//////////////////////////////////////////////////
// chip RAM
//////////////////////////////////////////////////

// address bits 31:21 must equal this for a chip RAM hit (2 MB window)
`define CHIP_TOP 11'd0
// long words actually built, higher addresses wrap
`define CHIP_DEPTH 256
// wishbone wait cycles before ack
`define CHIP_WAIT 2

`endif

//--- cycleDecode.sv
/*
 * stage 1: samples a 68040 transfer start and decodes it
 * holds one request for the access engine, unmapped cycles are dropped
 */
`timescale 1ns/1ns
`default_nettype none
`include "cpuBus_consts.svh"

module cycleDecode (
    input  wire                 CLK80,
    input  wire                 RESETn,
    input  wire                 tsN,
    input  wire [31:0]          addr,
    input  wire                 rw,
    input  wire cpuBusPkg::xferSize siz,
    input  wire [31:0]          dataIn,
    input  wire                 reqReady,
    output logic                reqValid,
    output cpuBusPkg::busReq    req
);

    cpuBusPkg::cpuAddr addrView;
    logic              start;
    logic              regHit;
    logic              chipHit;
    logic              canLoad;
    logic [3:0]        lanes;

    assign addrView = addr;
    assign start    = !tsN;

    // register page needs the spare bits clear, only 8 registers decode
    assign regHit  = (addrView.regView.page == `REG_PAGE)
                     && (addrView.regView.spare == 7'd0);
    assign chipHit = (addrView.chipView.top == `CHIP_TOP);

    // stage is free, or its request leaves this edge
    assign canLoad = !reqValid || reqReady;

    //////////////////////////////////////////////////
    // big-endian byte lanes, lane 3 is data 31:24
    //////////////////////////////////////////////////
    always_comb begin
        case (siz)
            cpuBusPkg::sizeByte: begin
                lanes = 4'b1000 >> addrView.chipView.byteOff;
            end
            cpuBusPkg::sizeWord: begin
                // words are aligned, offset bit 1 picks the half
                lanes = addrView.chipView.byteOff[1] ? 4'b0011 : 4'b1100;
            end
            default: begin
                // long and line, burst inhibit turns lines into longs
                lanes = 4'b1111;
            end
        endcase
    end

    // valid flag
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            reqValid <= 1'b0;
        end else if (start && (regHit || chipHit) && canLoad) begin
            reqValid <= 1'b1;
        end else if (reqReady) begin
            reqValid <= 1'b0;
        end
    end

    // request payload, captured with the start
    always_ff @(posedge CLK80) begin
        if (start && canLoad) begin
            req.region <= regHit ? cpuBusPkg::regionReg : cpuBusPkg::regionChip;
            // rw high is a read
            req.write  <= !rw;
            req.addr   <= addrView;
            req.lanes  <= lanes;
            req.wdata  <= dataIn;
        end
    end

    // the CPU never starts a new cycle before the last one drained
    startWhileFull: assert property (@(posedge CLK80) disable iff (!RESETn)
        start |-> !(reqValid && !reqReady))
        else $error("transfer start lost, decode stage still full");

endmodule

`default_nettype wire

//--- cycleTerm.sv
/*
 * stage 3: 68040 cycle termination
 * drives TBI/TCI for the whole window and TA low for two cycles on a CPU phase
 */
`timescale 1ns/1ns
`default_nettype none

module cycleTerm (
    input  wire                 CLK80,
    input  wire                 RESETn,
    input  wire                 rspValid,
    input  wire cpuBusPkg::busRsp rsp,
    output logic                rspReady,
    output logic                tackN,
    output logic                tbiN,
    output logic                tciN,
    output logic                busDrive,
    output logic [31:0]         dataOut,
    output logic                dataDrive
);

    typedef enum logic [2:0] {
        termIdle,
        termPhase,
        termAck,
        termAckHold,
        termRelease
    } termState;

    termState state;
    // stands in for the half rate CPU clock
    logic     cpuPhase;

    assign rspReady = (state == termIdle);

    // no bursts and no caching, low whenever the strobes are driven
    assign tbiN = ~busDrive;
    assign tciN = ~busDrive;

    //////////////////////////////////////////////////
    // termination FSM
    //////////////////////////////////////////////////
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state     <= termIdle;
            cpuPhase  <= 1'b0;
            tackN     <= 1'b1;
            busDrive  <= 1'b0;
            dataDrive <= 1'b0;
        end else begin
            cpuPhase <= ~cpuPhase;
            case (state)
                termIdle: begin
                    if (rspValid) begin
                        busDrive  <= 1'b1;
                        // data bus only for reads
                        dataDrive <= !rsp.write;
                        state     <= termPhase;
                    end
                end
                termPhase: begin
                    // align TA with the CPU clock
                    if (cpuPhase) begin
                        tackN <= 1'b0;
                        state <= termAck;
                    end
                end
                termAck: begin
                    state <= termAckHold;
                end
                termAckHold: begin
                    // negate TA before letting go
                    tackN <= 1'b1;
                    state <= termRelease;
                end
                termRelease: begin
                    busDrive  <= 1'b0;
                    dataDrive <= 1'b0;
                    state     <= termIdle;
                end
                default: begin
                    state <= termIdle;
                end
            endcase
        end
    end

    // read data latched with the response
    always_ff @(posedge CLK80) begin
        if (rspValid && rspReady) begin
            dataOut <= rsp.rdata;
        end
    end

    // TA only inside the window, and driven high once more after it
    tackInWindow: assert property (@(posedge CLK80) disable iff (!RESETn)
        !tackN |-> busDrive ##1 busDrive)
        else $error("TA asserted outside the drive window");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the cpuBusTop testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpuBusTop.f --top-module tbCpuBus -o simCpuBus
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/simCpuBus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tbCpuBus.sv
/*
 * directed testbench for the 68040 slave bus controller
 * a simple CPU master model issues cycles, a software model predicts the data
 */
`timescale 1ns/1ns
`default_nettype none
`include "cpuBus_consts.svh"

module tbCpuBus;

    localparam int chipBits  = $clog2(`CHIP_DEPTH);
    // generous bound on start to TA and on the drive release
    localparam int ackLimit  = 24;
    // unmapped cycles must stay silent this long
    localparam int dropLimit = 40;

    logic               CLK80 = 1'b0;
    logic               RESETn;
    logic               tsN;
    logic [31:0]        addr;
    logic               rw;
    cpuBusPkg::xferSize siz;
    logic [31:0]        dataIn;
    logic               tackN;
    logic               tbiN;
    logic               tciN;
    logic               busDrive;
    logic [31:0]        dataOut;
    logic               dataDrive;

    integer      seed = 32'h81be_dcea;
    int          errors;
    int          timeouts;
    // software copies of the register file and chip RAM
    logic [31:0] regModel [`REG_COUNT];
    logic [31:0] chipModel [`CHIP_DEPTH];

    always #5 CLK80 = ~CLK80;

    cpuBusTop uut (
        .CLK80     (CLK80),
        .RESETn    (RESETn),
        .tsN       (tsN),
        .addr      (addr),
        .rw        (rw),
        .siz       (siz),
        .dataIn    (dataIn),
        .tackN     (tackN),
        .tbiN      (tbiN),
        .tciN      (tciN),
        .busDrive  (busDrive),
        .dataOut   (dataOut),
        .dataDrive (dataDrive)
    );

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic checkData(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // TA only in the window, TBI and TCI low all through it
    task automatic checkStrobes();
        if (tackN === 1'b0 && busDrive !== 1'b1) begin
            errors++;
            $display("ERR %0t: tackN low without busDrive", $time);
        end
        if (busDrive === 1'b1 && (tbiN !== 1'b0 || tciN !== 1'b0)) begin
            errors++;
            $display("ERR %0t: tbiN %b tciN %b inside drive window", $time, tbiN, tciN);
        end
    endtask

    //////////////////////////////////////////////////
    // model helpers
    //////////////////////////////////////////////////

    // big-endian lanes, offset 0 is data 31:24
    function automatic logic [31:0] laneMask(input cpuBusPkg::xferSize sz,
            input logic [1:0] off);
        case (sz)
            cpuBusPkg::sizeByte: laneMask = 32'hFF00_0000 >> (8 * off);
            cpuBusPkg::sizeWord: laneMask = off[1] ? 32'h0000_FFFF : 32'hFFFF_0000;
            default:             laneMask = 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic logic [31:0] regAddr(input logic [2:0] idx, input logic [1:0] off);
        return {`REG_PAGE, 7'd0, idx, off};
    endfunction

    function automatic logic [31:0] chipAddr(input logic [18:0] la, input logic [1:0] off);
        return {`CHIP_TOP, la, off};
    endfunction

    // chip RAM keeps only the low long address bits
    function automatic logic [chipBits-1:0] chipIdx(input logic [18:0] la);
        return chipBits'(la % `CHIP_DEPTH);
    endfunction

    //////////////////////////////////////////////////
    // 68040 master model
    //////////////////////////////////////////////////

    // called on a falling edge, rel waits for the drives to let go
    task automatic cpuCycle(input logic [31:0] a, input logic isRead,
            input cpuBusPkg::xferSize sz, input logic [31:0] wd, input bit rel,
            output logic [31:0] rd);
        int n;
        int lowCount;
        rd     = 32'd0;
        tsN    = 1'b0;
        addr   = a;
        rw     = isRead;
        siz    = sz;
        dataIn = wd;
        @(negedge CLK80);
        tsN = 1'b1;
        n   = 0;
        while (tackN !== 1'b0 && n < ackLimit) begin
            checkStrobes();
            @(negedge CLK80);
            n++;
        end
        if (tackN !== 1'b0) begin
            timeouts++;
            $display("timeout: no transfer acknowledge for address %h", a);
            return;
        end
        // n counts edges from the sampled start to TA low
        checkFlag("acknowledge latency in range",
            (n >= 3) && (n <= `CHIP_WAIT + 6), 1'b1);
        rd = dataOut;
        checkFlag("dataDrive at acknowledge", dataDrive, isRead);
        lowCount = 0;
        while (tackN === 1'b0 && lowCount < ackLimit) begin
            checkStrobes();
            lowCount++;
            @(negedge CLK80);
        end
        checkCount("acknowledge low cycles", lowCount, 2);
        // TA negated once while still driven
        checkFlag("busDrive after acknowledge", busDrive, 1'b1);
        checkStrobes();
        if (rel) begin
            n = 0;
            while (busDrive !== 1'b0 && n < ackLimit) begin
                @(negedge CLK80);
                n++;
            end
            if (busDrive !== 1'b0) begin
                timeouts++;
                $display("timeout: busDrive never released for address %h", a);
                return;
            end
            checkFlag("dataDrive released", dataDrive, 1'b0);
        end
    endtask

    task automatic regWrite(input logic [2:0] idx, input logic [1:0] off,
            input cpuBusPkg::xferSize sz, input logic [31:0] wd, input bit rel);
        logic [31:0] m;
        logic [31:0] rd;
        m = laneMask(sz, off);
        regModel[idx] = (regModel[idx] & ~m) | (wd & m);
        cpuCycle(regAddr(idx, off), 1'b0, sz, wd, rel, rd);
    endtask

    task automatic regRead(input logic [2:0] idx, input bit rel);
        logic [31:0] rd;
        cpuCycle(regAddr(idx, 2'd0), 1'b1, cpuBusPkg::sizeLong, 32'd0, rel, rd);
        checkData($sformatf("register %0d", idx), rd, regModel[idx]);
    endtask

    task automatic chipWrite(input logic [18:0] la, input logic [1:0] off,
            input cpuBusPkg::xferSize sz, input logic [31:0] wd, input bit rel);
        logic [31:0] m;
        logic [31:0] rd;
        m = laneMask(sz, off);
        chipModel[chipIdx(la)] = (chipModel[chipIdx(la)] & ~m) | (wd & m);
        cpuCycle(chipAddr(la, off), 1'b0, sz, wd, rel, rd);
    endtask

    task automatic chipRead(input logic [18:0] la, input cpuBusPkg::xferSize sz,
            input bit rel);
        logic [31:0] rd;
        cpuCycle(chipAddr(la, 2'd0), 1'b1, sz, 32'd0, rel, rd);
        checkData($sformatf("chip RAM long %h", la), rd, chipModel[chipIdx(la)]);
    endtask

    // nobody here owns this address, the bus must stay quiet
    task automatic ignoredCycle(input logic [31:0] a);
        int  n;
        logic rose;
        tsN    = 1'b0;
        addr   = a;
        rw     = 1'b1;
        siz    = cpuBusPkg::sizeLong;
        dataIn = 32'd0;
        @(negedge CLK80);
        tsN  = 1'b1;
        rose = 1'b0;
        n    = 0;
        while (!rose && n < dropLimit) begin
            if (busDrive !== 1'b0 || tackN !== 1'b1) begin
                rose = 1'b1;
            end
            @(negedge CLK80);
            n++;
        end
        if (rose) begin
            errors++;
            $display("ERR %0t: unmapped address %h was terminated", $time, a);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic testReset();
        checkFlag("busDrive after reset", busDrive, 1'b0);
        checkFlag("dataDrive after reset", dataDrive, 1'b0);
        checkFlag("tackN after reset", tackN, 1'b1);
        checkFlag("tbiN after reset", tbiN, 1'b1);
        checkFlag("tciN after reset", tciN, 1'b1);
        for (int i = 0; i < `REG_COUNT; i++) begin
            regRead(3'(i), 1'b1);
        end
    endtask

    task automatic testRegLong();
        for (int i = 0; i < `REG_COUNT; i++) begin
            regWrite(3'(i), 2'd0, cpuBusPkg::sizeLong, $random(seed), 1'b1);
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            regRead(3'(i), 1'b1);
        end
    endtask

    task automatic testRegLanes();
        regWrite(3'd2, 2'd0, cpuBusPkg::sizeLong, 32'h1122_3344, 1'b1);
        for (int k = 0; k < 4; k++) begin
            regWrite(3'd2, 2'(k), cpuBusPkg::sizeByte, $random(seed), 1'b1);
            regRead(3'd2, 1'b1);
        end
        regWrite(3'd5, 2'd0, cpuBusPkg::sizeLong, 32'hA5A5_5A5A, 1'b1);
        regWrite(3'd5, 2'd2, cpuBusPkg::sizeWord, $random(seed), 1'b1);
        regRead(3'd5, 1'b1);
        regWrite(3'd5, 2'd0, cpuBusPkg::sizeWord, $random(seed), 1'b1);
        regRead(3'd5, 1'b1);
    endtask

    task automatic testChip();
        // fill every word that is read later, first and last entry too
        chipWrite(19'd0, 2'd0, cpuBusPkg::sizeLong, $random(seed), 1'b1);
        chipWrite(19'd1, 2'd0, cpuBusPkg::sizeLong, $random(seed), 1'b1);
        chipWrite(19'd5, 2'd0, cpuBusPkg::sizeLong, $random(seed), 1'b1);
        chipWrite(19'd37, 2'd0, cpuBusPkg::sizeLong, $random(seed), 1'b1);
        chipWrite(19'd100, 2'd0, cpuBusPkg::sizeLong, $random(seed), 1'b1);
        chipWrite(19'd255, 2'd0, cpuBusPkg::sizeLong, $random(seed), 1'b1);
        for (int k = 0; k < 4; k++) begin
            chipWrite(19'd1, 2'(k), cpuBusPkg::sizeByte, $random(seed), 1'b1);
        end
        chipWrite(19'd100, 2'd2, cpuBusPkg::sizeWord, $random(seed), 1'b1);
        chipWrite(19'd100, 2'd0, cpuBusPkg::sizeWord, $random(seed), 1'b1);
        // past the implemented depth, lands on entry 37
        chipWrite(19'(`CHIP_DEPTH + 37), 2'd0, cpuBusPkg::sizeLong, $random(seed), 1'b1);
        // line size falls back to a long word
        chipWrite(19'd5, 2'd0, cpuBusPkg::sizeLine, $random(seed), 1'b1);
        chipRead(19'd0, cpuBusPkg::sizeLong, 1'b1);
        chipRead(19'd1, cpuBusPkg::sizeLong, 1'b1);
        chipRead(19'd5, cpuBusPkg::sizeLine, 1'b1);
        chipRead(19'd37, cpuBusPkg::sizeLong, 1'b1);
        chipRead(19'd100, cpuBusPkg::sizeLong, 1'b1);
        chipRead(19'd255, cpuBusPkg::sizeLong, 1'b1);
        // top of the window wraps onto the last entry
        chipRead(19'h7FFFF, cpuBusPkg::sizeLong, 1'b1);
    endtask

    task automatic testUnmapped();
        // above chip RAM, outside the register page
        ignoredCycle(32'h8000_0040);
        // register page with a spare bit set
        ignoredCycle({`REG_PAGE, 7'h08, 3'd1, 2'd0});
        regRead(3'd4, 1'b1);
        chipRead(19'd37, cpuBusPkg::sizeLong, 1'b1);
    endtask

    // each start follows the previous TA negation directly
    task automatic testBackToBack();
        regWrite(3'd3, 2'd0, cpuBusPkg::sizeLong, $random(seed), 1'b0);
        chipWrite(19'd60, 2'd0, cpuBusPkg::sizeLong, $random(seed), 1'b0);
        regRead(3'd3, 1'b0);
        chipRead(19'd60, cpuBusPkg::sizeLong, 1'b0);
        regWrite(3'd3, 2'd1, cpuBusPkg::sizeByte, $random(seed), 1'b0);
        chipWrite(19'd60, 2'd0, cpuBusPkg::sizeWord, $random(seed), 1'b0);
        regRead(3'd3, 1'b0);
        chipRead(19'd60, cpuBusPkg::sizeLong, 1'b1);
    endtask

    //////////////////////////////////////////////////
    // run
    //////////////////////////////////////////////////
    initial begin
        errors    = 0;
        timeouts  = 0;
        regModel  = '{default: '0};
        chipModel = '{default: '0};
        RESETn    = 1'b0;
        tsN       = 1'b1;
        addr      = 32'd0;
        rw        = 1'b1;
        siz       = cpuBusPkg::sizeLong;
        dataIn    = 32'd0;
        repeat (3) @(posedge CLK80);
        @(negedge CLK80);
        RESETn = 1'b1;

        testReset();
        testRegLong();
        testRegLanes();
        testChip();
        testUnmapped();
        testBackToBack();

        $display("run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
